// ==== project.f ====
+incdir+tb
rtl/qrd_pkg.sv
rtl/cordic_prerotate.sv
rtl/cordic_stage.sv
rtl/cordic_rotator.sv
rtl/givens_cell.sv
tb/tb_givens_cell.sv

// ==== rtl/cordic_prerotate.sv ====
`timescale 1ns/1ps

module cordic_prerotate import qrd_pkg::*; #(
    parameter int WIDTH = DATA_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    vec_i,
    input  logic signed [WIDTH-1:0] x_i,
    input  logic signed [WIDTH-1:0] y_i,
    output logic signed [WIDTH-1:0] x_o,
    output logic signed [WIDTH-1:0] y_o,
    output logic                    vec_o
);

    logic                    x_neg;
    logic                    flip;
    logic                    sign_r;
    logic signed [WIDTH-1:0] x_fix;
    logic signed [WIDTH-1:0] y_fix;

    assign x_neg = x_i[WIDTH-1];

    // rotation items follow the sign of the last vectoring item
    assign flip = vec_i ? x_neg : sign_r;

    // half-plane fold, a rotation by pi
    always_comb begin
        if (flip) begin
            x_fix = -x_i;
            y_fix = -y_i;
        end else begin
            x_fix = x_i;
            y_fix = y_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sign_r <= 1'b0;
        end else if (vec_i) begin
            sign_r <= x_neg;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vec_o <= 1'b0;
        end else begin
            vec_o <= vec_i;
        end
    end

    always_ff @(posedge clk) begin
        x_o <= x_fix;
        y_o <= y_fix;
    end

endmodule

// ==== rtl/cordic_rotator.sv ====
`timescale 1ns/1ps

module cordic_rotator import qrd_pkg::*; #(
    parameter int WIDTH     = DATA_WIDTH,
    parameter int ITER      = N_ITER,
    parameter int GAIN_FRAC = qrd_pkg::GAIN_FRAC,
    parameter int GAIN      = GAIN_CONST
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    vec_i,
    input  logic signed [WIDTH-1:0] x_i,
    input  logic signed [WIDTH-1:0] y_i,
    output logic                    vec_o,
    output logic signed [WIDTH-1:0] x_o,
    output logic signed [WIDTH-1:0] y_o
);

    // gain is below one, so one sign bit over the fraction is enough
    localparam logic signed [GAIN_FRAC:0] GAIN_S = (GAIN_FRAC + 1)'(GAIN);

    logic signed [WIDTH-1:0]         x_s [0:ITER];
    logic signed [WIDTH-1:0]         y_s [0:ITER];
    logic        [ITER:0]            vec_s;
    logic        [ITER:0]            rot_s;
    logic signed [WIDTH+GAIN_FRAC:0] x_prod;
    logic signed [WIDTH+GAIN_FRAC:0] y_prod;
    logic signed [WIDTH-1:0]         x_gain;
    logic signed [WIDTH-1:0]         y_gain;

    cordic_prerotate #(
        .WIDTH (WIDTH)
    ) u_prerotate (
        .clk   (clk),
        .rst_n (rst_n),
        .vec_i (vec_i),
        .x_i   (x_i),
        .y_i   (y_i),
        .x_o   (x_s[0]),
        .y_o   (y_s[0]),
        .vec_o (vec_s[0])
    );

    // nothing rotated before the first stage
    assign rot_s[0] = 1'b0;

    for (genvar gi = 0; gi < ITER; gi++) begin : g_stage
        cordic_stage #(
            .WIDTH (WIDTH),
            .SHIFT (gi)
        ) u_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .vec_i     (vec_s[gi]),
            .rotated_i (rot_s[gi]),
            .x_i       (x_s[gi]),
            .y_i       (y_s[gi]),
            .vec_o     (vec_s[gi+1]),
            .rotated_o (rot_s[gi+1]),
            .x_o       (x_s[gi+1]),
            .y_o       (y_s[gi+1])
        );
    end

    assign x_prod = x_s[ITER] * GAIN_S;
    assign y_prod = y_s[ITER] * GAIN_S;

    // drop the fraction bits
    assign x_gain = x_prod[GAIN_FRAC +: WIDTH];
    assign y_gain = y_prod[GAIN_FRAC +: WIDTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vec_o <= 1'b0;
        end else begin
            vec_o <= vec_s[ITER];
        end
    end

    // unrotated items carry no CORDIC growth
    always_ff @(posedge clk) begin
        if (rot_s[ITER]) begin
            x_o <= x_gain;
            y_o <= y_gain;
        end else begin
            x_o <= x_s[ITER];
            y_o <= y_s[ITER];
        end
    end

endmodule

// ==== rtl/cordic_stage.sv ====
`timescale 1ns/1ps

module cordic_stage import qrd_pkg::*; #(
    parameter int WIDTH = DATA_WIDTH,
    parameter int SHIFT = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    vec_i,
    input  logic                    rotated_i,
    input  logic signed [WIDTH-1:0] x_i,
    input  logic signed [WIDTH-1:0] y_i,
    output logic                    vec_o,
    output logic                    rotated_o,
    output logic signed [WIDTH-1:0] x_o,
    output logic signed [WIDTH-1:0] y_o
);

    logic                    dir_r;
    logic                    upd_r;
    logic                    dir;
    logic                    upd;
    logic signed [WIDTH-1:0] x_sh;
    logic signed [WIDTH-1:0] y_sh;
    logic signed [WIDTH-1:0] x_nxt;
    logic signed [WIDTH-1:0] y_nxt;

    // vectoring drives y toward zero
    assign dir = vec_i ? (y_i > 0) : dir_r;
    assign upd = vec_i ? (y_i != 0) : upd_r;

    assign x_sh = x_i >>> SHIFT;
    assign y_sh = y_i >>> SHIFT;

    always_comb begin
        if (!upd) begin
            x_nxt = x_i;
            y_nxt = y_i;
        end else if (dir) begin
            // clockwise
            x_nxt = x_i + y_sh;
            y_nxt = y_i - x_sh;
        end else begin
            x_nxt = x_i - y_sh;
            y_nxt = y_i + x_sh;
        end
    end

    // decisions held for the rotation items behind
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dir_r <= 1'b0;
            upd_r <= 1'b0;
        end else if (vec_i) begin
            dir_r <= dir;
            upd_r <= upd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vec_o     <= 1'b0;
            rotated_o <= 1'b0;
        end else begin
            vec_o     <= vec_i;
            rotated_o <= rotated_i | upd;
        end
    end

    always_ff @(posedge clk) begin
        x_o <= x_nxt;
        y_o <= y_nxt;
    end

endmodule

// ==== rtl/givens_cell.sv ====
`timescale 1ns/1ps

module givens_cell import qrd_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    vec_i,
    input  sample_t x_i,
    input  sample_t y_i,
    output logic    vec_o,
    output sample_t x_o,
    output sample_t y_o
);

    logic    rot_vec;
    sample_t rot_x;
    sample_t rot_y;

    cordic_rotator #(
        .WIDTH     (DATA_WIDTH),
        .ITER      (N_ITER),
        .GAIN_FRAC (GAIN_FRAC),
        .GAIN      (GAIN_CONST)
    ) u_rotator (
        .clk   (clk),
        .rst_n (rst_n),
        .vec_i (vec_i),
        .x_i   (x_i),
        .y_i   (y_i),
        .vec_o (rot_vec),
        .x_o   (rot_x),
        .y_o   (rot_y)
    );

    assign vec_o = rot_vec;
    assign x_o   = rot_x;

    // the annihilated element leaves as an exact zero
    // any CORDIC residue in y is discarded
    assign y_o = rot_vec ? '0 : rot_y;

endmodule

// ==== rtl/qrd_pkg.sv ====
package qrd_pkg;

    // word width of x and y
    localparam int DATA_WIDTH = 14;

    // micro-rotations, one pipeline stage each
    localparam int N_ITER = 8;

    // gain compensation in fixed point
    // 622 / 1024 is close to 0.6073, the 8-stage CORDIC scale
    localparam int GAIN_FRAC  = 10;
    localparam int GAIN_CONST = 622;

    // prerotation, the stages, then the gain register
    localparam int PIPE_DEPTH = N_ITER + 2;

    typedef logic signed [DATA_WIDTH-1:0] sample_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the givens_cell testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_givens_cell \
    -Mdir obj_dir \
    && ./obj_dir/Vtb_givens_cell > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^All checks passed$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== tb/givens_model.svh ====
`ifndef GIVENS_MODEL_SVH
`define GIVENS_MODEL_SVH

// decisions left behind by the last vectoring item
logic model_sign;
logic model_dir [N_ITER];
logic model_upd [N_ITER];

function automatic void clear_model();
    model_sign = 1'b0;
    for (int i = 0; i < N_ITER; i++) begin
        model_dir[i] = 1'b0;
        model_upd[i] = 1'b0;
    end
endfunction

// expected x_o and y_o of one item, items taken in issue order
function automatic void predict_output(
    input  logic    vec,
    input  sample_t x_in,
    input  sample_t y_in,
    output sample_t x_exp,
    output sample_t y_exp
);
    sample_t x;
    sample_t y;
    sample_t x_sh;
    sample_t y_sh;
    logic    flip;
    logic    dir;
    logic    upd;
    logic    rotated;
    int      x_full;
    int      y_full;

    x = x_in;
    y = y_in;

    // fold into the right half plane
    if (vec) begin
        flip       = x[DATA_WIDTH-1];
        model_sign = flip;
    end else begin
        flip = model_sign;
    end
    if (flip) begin
        x = -x;
        y = -y;
    end

    rotated = 1'b0;
    for (int i = 0; i < N_ITER; i++) begin
        if (vec) begin
            dir          = (y > 0);
            upd          = (y != 0);
            model_dir[i] = dir;
            model_upd[i] = upd;
        end else begin
            dir = model_dir[i];
            upd = model_upd[i];
        end
        x_sh = x >>> i;
        y_sh = y >>> i;
        if (upd && dir) begin
            x = x + y_sh;
            y = y - x_sh;
        end else if (upd) begin
            x = x - y_sh;
            y = y + x_sh;
        end
        rotated = rotated | upd;
    end

    // scale back by the CORDIC gain, floor on the dropped fraction
    if (rotated) begin
        x_full = int'(x) * GAIN_CONST;
        y_full = int'(y) * GAIN_CONST;
        x      = sample_t'(x_full >>> GAIN_FRAC);
        y      = sample_t'(y_full >>> GAIN_FRAC);
    end

    x_exp = x;
    y_exp = vec ? sample_t'(0) : y;
endfunction

`endif

// ==== tb/tb_givens_cell.sv ====
`timescale 1ns/1ps

module tb_givens_cell import qrd_pkg::*; ();

    localparam int RESET_CYCLES  = 10;
    localparam int N_RESET_ROT   = 12;
    localparam int N_VEC         = 40;
    localparam int N_ROT_GROUPS  = 10;
    localparam int ROT_PER_GROUP = 6;
    localparam int N_QUAD_GROUPS = 8;
    localparam int N_ZERO_GROUPS = 6;
    localparam int ROT_AFTER     = 4;
    localparam int N_STREAM      = 200;

    // 392 items plus reset and latency come to about 412 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        int      tag;
        logic    vec;
        sample_t x;
        sample_t y;
    } expect_t;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    vec_i;
    sample_t x_i;
    sample_t y_i;
    logic    vec_o;
    sample_t x_o;
    sample_t y_o;

    int      cycle = 0;
    int      seed = 32'h1fb9b649;
    int      rel_cycle = 0;
    bit      released = 1'b0;
    expect_t exp_q [$];

    `include "givens_model.svh"

    givens_cell dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .vec_i (vec_i),
        .x_i   (x_i),
        .y_i   (y_i),
        .vec_o (vec_o),
        .x_o   (x_o),
        .y_o   (y_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("TIMEOUT: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "stopping on timeout");
        end
    end

    task automatic check_sample(input string name, input sample_t exp_val,
                                input sample_t act_val);
        if (act_val !== exp_val) begin
            $display("MISMATCH %s at cycle %0d: expected 0x%h, got 0x%h",
                     name, cycle, exp_val, act_val);
            $display("Checks failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("MISMATCH %s at cycle %0d: expected 0x%h, got 0x%h",
                     name, cycle, exp_val, act_val);
            $display("Checks failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // values kept small enough that the norm times the CORDIC growth fits
    function automatic sample_t rand_sample();
        int r;
        r = $random(seed) % 2048;
        return sample_t'(r);
    endfunction

    function automatic sample_t rand_negative();
        int r;
        r = $random(seed) % 2047;
        if (r < 0) begin
            r = -r;
        end
        return sample_t'(-(r + 1));
    endfunction

    // drive one item now, then step to the next drive point
    task automatic send_item(input logic vec, input sample_t x, input sample_t y);
        sample_t x_exp;
        sample_t y_exp;
        expect_t e;
        predict_output(vec, x, y, x_exp, y_exp);
        vec_i = vec;
        x_i   = x;
        y_i   = y;
        e.tag = cycle;
        e.vec = vec;
        e.x   = x_exp;
        e.y   = y_exp;
        exp_q.push_back(e);
        @(posedge clk);
        #1;
    endtask

    task automatic run_reset_rotations();
        repeat (N_RESET_ROT) send_item(1'b0, rand_sample(), rand_sample());
    endtask

    task automatic run_vectoring();
        repeat (N_VEC) send_item(1'b1, rand_sample(), rand_sample());
    endtask

    task automatic run_stored_rotation();
        repeat (N_ROT_GROUPS) begin
            send_item(1'b1, rand_sample(), rand_sample());
            repeat (ROT_PER_GROUP) send_item(1'b0, rand_sample(), rand_sample());
        end
    endtask

    task automatic run_quadrant();
        repeat (N_QUAD_GROUPS) begin
            send_item(1'b1, rand_negative(), rand_sample());
            repeat (ROT_AFTER) send_item(1'b0, rand_sample(), rand_sample());
        end
    endtask

    task automatic run_zero_y();
        repeat (N_ZERO_GROUPS) begin
            send_item(1'b1, rand_sample(), sample_t'(0));
            repeat (ROT_AFTER) send_item(1'b0, rand_sample(), rand_sample());
        end
    endtask

    // roughly one vectoring item in four
    task automatic run_mixed_stream();
        logic vec;
        repeat (N_STREAM) begin
            vec = (($random(seed) & 3) == 0);
            send_item(vec, rand_sample(), rand_sample());
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (released && cycle >= rel_cycle && cycle < rel_cycle + PIPE_DEPTH) begin
            check_flag("vec_o", 1'b0, vec_o);
        end
        if (exp_q.size() > 0 && exp_q[0].tag + PIPE_DEPTH == cycle) begin
            e = exp_q.pop_front();
            check_flag("vec_o", e.vec, vec_o);
            check_sample("x_o", e.x, x_o);
            check_sample("y_o", e.y, y_o);
        end
    end

    initial begin
        // a vectoring item with negative x held during reset leaves nothing behind
        rst_n = 1'b0;
        vec_i = 1'b1;
        x_i   = sample_t'(-1000);
        y_i   = sample_t'(500);
        clear_model();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n     = 1'b1;
        rel_cycle = cycle;
        released  = 1'b1;

        run_reset_rotations();
        run_vectoring();
        run_stored_rotation();
        run_quadrant();
        run_zero_y();
        run_mixed_stream();

        vec_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end

        $display("All checks passed");
        $finish;
    end

endmodule
